/* src/sdramFsmPkg.sv */
// shared types for the SDRAM write/readback sequencer
// addresses are ADDR_BITS wide and wrap modulo the depth
// the config block stores a wordCount of 0 as 1

package sdramFsmPkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int ADDR_BITS = 6;   // enough for depth 64
    localparam int DATA_BITS = 16;

    // ------------------------------
    // run configuration
    // ------------------------------
    typedef struct packed {
        logic [ADDR_BITS-1:0] baseAddr;   // first address written
        logic [7:0]           wordCount;  // 1..255
        logic [3:0]           firstDigit; // hex digit of word 0
    } cfg_t;

    // ------------------------------
    // memory word seen two ways
    // ------------------------------
    typedef struct packed {
        logic [7:0] tag;   // sequence index mod 256
        logic       dp;    // odd index
        logic [6:0] segs;  // a..g, a is msb
    } segWord_t;

    typedef union packed {
        logic [DATA_BITS-1:0] raw;  // memory side
        segWord_t             seg;  // sequencer / checker side
    } sdramWord_u;

    // ------------------------------
    // memory requests
    // ------------------------------
    typedef struct packed {
        logic [ADDR_BITS-1:0] addr;
        sdramWord_u           data;
    } wrReq_t;  // valid with WrRequest

    typedef struct packed {
        logic [ADDR_BITS-1:0] addr;
    } rdReq_t;  // valid with RdRequest

endpackage

/* src/segmentEncoder.sv */
// hex digit to seven-segment pattern, purely combinational
// active-high segments, a is bit 6 and g is bit 0
// no decimal point here, the caller adds it

module segmentEncoder (
    input  logic [3:0] digit,
    output logic [6:0] segs
);

    // abcdefg
    always_comb begin
        case (digit)
            4'h0: segs = 7'h7E;
            4'h1: segs = 7'h30;  // b c
            4'h2: segs = 7'h6D;
            4'h3: segs = 7'h79;
            4'h4: segs = 7'h33;
            4'h5: segs = 7'h5B;
            4'h6: segs = 7'h5F;
            4'h7: segs = 7'h70;  // a b c
            4'h8: segs = 7'h7F;  // all on
            4'h9: segs = 7'h7B;
            4'hA: segs = 7'h77;
            4'hB: segs = 7'h1F;  // lower case b
            4'hC: segs = 7'h4E;
            4'hD: segs = 7'h3D;  // lower case d
            4'hE: segs = 7'h4F;
            4'hF: segs = 7'h47;
            default: segs = 7'h00;
        endcase
    end

endmodule

/* src/fsmConfigRegs.sv */
// run configuration registers, written by a single-cycle strobe
// select 0 base address, 1 word count, 2 first digit, 3 ignored
// base address is kept modulo MemDepth, word count 0 is stored as 1
// the sequencer copies these at start, so writes mid-run are safe

module fsmConfigRegs #(
    parameter int MemDepth = 64
) (
    input  logic               Clock,
    input  logic               rstN,
    input  logic               CfgWrite,
    input  logic [1:0]         CfgSel,
    input  logic [7:0]         CfgData,
    output sdramFsmPkg::cfg_t  cfg
);

    localparam logic [sdramFsmPkg::ADDR_BITS-1:0] AddrMask =
        sdramFsmPkg::ADDR_BITS'(MemDepth - 1);

    logic [sdramFsmPkg::ADDR_BITS-1:0] baseAddrQ;
    logic [7:0]                        wordCountQ;
    logic [3:0]                        firstDigitQ;

    // ------------------------------
    // strobe writes
    // ------------------------------
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            baseAddrQ   <= '0;
            wordCountQ  <= 8'd16;   // one full digit sweep
            firstDigitQ <= 4'h0;
        end else if (CfgWrite) begin
            case (CfgSel)
                2'd0: baseAddrQ <= CfgData[sdramFsmPkg::ADDR_BITS-1:0] & AddrMask;
                2'd1: wordCountQ <= (CfgData == 8'd0) ? 8'd1 : CfgData;
                2'd2: firstDigitQ <= CfgData[3:0];  // low nibble only
                default: ;  // select 3 unused
            endcase
        end
    end

    always_comb begin
        cfg.baseAddr   = baseAddrQ;
        cfg.wordCount  = wordCountQ;
        cfg.firstDigit = firstDigitQ;
    end

endmodule

/* src/sdramFsm.sv */
// write-then-read sequencer with readback compare
// word i goes to (baseAddr + i) mod MemDepth, one access per cycle
// memory must return read data on the edge after RdRequest
// StartWr is ignored while Busy and there is no back-pressure
// MismatchCount saturates at 255 and is final in the Done cycle

module sdramFsm #(
    parameter int MemDepth = 64
) (
    input  logic                    Clock,
    input  logic                    rstN,
    input  logic                    StartWr,
    input  sdramFsmPkg::cfg_t       cfg,
    input  sdramFsmPkg::sdramWord_u MemData,
    output logic                    WrRequest,
    output sdramFsmPkg::wrReq_t     wrReq,
    output logic                    RdRequest,
    output sdramFsmPkg::rdReq_t     rdReq,
    output logic                    ReadValid,
    output sdramFsmPkg::sdramWord_u ReadData,
    output logic [7:0]              ReadIndex,
    output logic                    Busy,
    output logic                    Done,
    output logic [7:0]              MismatchCount
);

    localparam logic [1:0] StIdle  = 2'd0;
    localparam logic [1:0] StWrite = 2'd1;
    localparam logic [1:0] StRead  = 2'd2;
    localparam logic [1:0] StDrain = 2'd3;

    localparam logic [sdramFsmPkg::ADDR_BITS-1:0] AddrMask =
        sdramFsmPkg::ADDR_BITS'(MemDepth - 1);

    logic [1:0]                        state;
    logic [7:0]                        wordIdx;     // index of current access
    logic                              lastWord;
    logic                              rdPending;   // read data arrives this cycle
    logic [7:0]                        rdIdxQ;      // index of that read
    logic                              doneQ;
    sdramFsmPkg::cfg_t                 runCfg;      // copy taken at start
    logic [sdramFsmPkg::ADDR_BITS-1:0] curAddr;
    logic [6:0]                        wrSegs;
    logic [6:0]                        expSegs;
    sdramFsmPkg::sdramWord_u           expWord;
    logic                              wordBad;

    // ------------------------------
    // word rule
    // ------------------------------
    segmentEncoder wrEnc (
        .digit (runCfg.firstDigit + wordIdx[3:0]),   // wraps mod 16
        .segs  (wrSegs)
    );

    segmentEncoder expEnc (
        .digit (runCfg.firstDigit + rdIdxQ[3:0]),
        .segs  (expSegs)
    );

    // 6-bit sum wraps mod 64 and the mask brings it to mod MemDepth
    assign curAddr  = (runCfg.baseAddr + sdramFsmPkg::ADDR_BITS'(wordIdx)) & AddrMask;
    assign lastWord = (wordIdx == runCfg.wordCount - 8'd1);

    always_comb begin
        wrReq.addr          = curAddr;
        wrReq.data.seg.tag  = wordIdx;
        wrReq.data.seg.dp   = wordIdx[0];
        wrReq.data.seg.segs = wrSegs;
        rdReq.addr          = curAddr;   // read i hits write i's address
    end

    always_comb begin
        expWord.seg.tag  = rdIdxQ;
        expWord.seg.dp   = rdIdxQ[0];
        expWord.seg.segs = expSegs;
    end

    assign wordBad = rdPending && (MemData.raw != expWord.raw);

    // ------------------------------
    // control FSM
    // ------------------------------
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            state         <= StIdle;
            wordIdx       <= '0;
            rdPending     <= 1'b0;
            doneQ         <= 1'b0;
            MismatchCount <= '0;
        end else begin
            rdPending <= (state == StRead);   // memory answers next edge
            doneQ     <= (state == StDrain);
            if (wordBad && MismatchCount != 8'hFF)
                MismatchCount <= MismatchCount + 8'd1;
            case (state)
                StIdle: begin
                    if (StartWr && !doneQ) begin   // Done cycle still counts as busy
                        state         <= StWrite;
                        wordIdx       <= '0;
                        MismatchCount <= '0;
                    end
                end
                StWrite: begin
                    wordIdx <= lastWord ? 8'd0 : wordIdx + 8'd1;
                    if (lastWord)
                        state <= StRead;
                end
                StRead: begin
                    wordIdx <= wordIdx + 8'd1;
                    if (lastWord)
                        state <= StDrain;
                end
                StDrain: state <= StIdle;   // last read returns here
                default: state <= StIdle;
            endcase
        end
    end

    // run copy and index of the read in flight
    always_ff @(posedge Clock) begin
        if (state == StIdle && StartWr && !doneQ)
            runCfg <= cfg;
        rdIdxQ <= wordIdx;
    end

    // ------------------------------
    // outputs
    // ------------------------------
    assign WrRequest = (state == StWrite);
    assign RdRequest = (state == StRead);
    assign ReadValid = rdPending;
    assign ReadData  = MemData;
    assign ReadIndex = rdIdxQ;
    assign Done      = doneQ;
    assign Busy      = (state != StIdle) || doneQ;

endmodule

/* src/demoSdram.sv */
// small single-port memory standing in for SDRAM
// MemDepth must be a power of two, 16 to 64
// upper address bits are dropped, write wins over read
// read data is registered, valid on the edge after RdRequest
// contents are not reset

module demoSdram #(
    parameter int MemDepth = 64
) (
    input  logic                    Clock,
    input  logic                    WrRequest,
    input  sdramFsmPkg::wrReq_t     wrReq,
    input  logic                    RdRequest,
    input  sdramFsmPkg::rdReq_t     rdReq,
    output sdramFsmPkg::sdramWord_u MemData
);

    localparam int IdxBits = $clog2(MemDepth);

    logic [sdramFsmPkg::DATA_BITS-1:0] mem [MemDepth];
    logic [IdxBits-1:0]                wrIdx;
    logic [IdxBits-1:0]                rdIdx;

    assign wrIdx = wrReq.addr[IdxBits-1:0];
    assign rdIdx = rdReq.addr[IdxBits-1:0];

    // ------------------------------
    // single port access
    // ------------------------------
    always_ff @(posedge Clock) begin
        if (WrRequest)
            mem[wrIdx] <= wrReq.data.raw;   // raw bits, no decode here
        else if (RdRequest)
            MemData.raw <= mem[rdIdx];
    end

endmodule

/* src/sdramFsmTop.sv */
// write-then-read test sequencer in front of a demo memory
// MemDepth is set here and passed down, power of two 16..64
// plain strobes and pulses, no handshake on any port
// config writes during a run take effect on the next run

module sdramFsmTop #(
    parameter int MemDepth = 64
) (
    input  logic                    Clock,
    input  logic                    rstN,
    input  logic                    StartWr,
    input  logic                    CfgWrite,
    input  logic [1:0]              CfgSel,
    input  logic [7:0]              CfgData,
    output logic                    ReadValid,
    output sdramFsmPkg::sdramWord_u ReadData,
    output logic [7:0]              ReadIndex,
    output logic                    Busy,
    output logic                    Done,
    output logic [7:0]              MismatchCount
);

    sdramFsmPkg::cfg_t       cfg;
    logic                    wrRequest;
    sdramFsmPkg::wrReq_t     wrReq;
    logic                    rdRequest;
    sdramFsmPkg::rdReq_t     rdReq;
    sdramFsmPkg::sdramWord_u memData;

    // ------------------------------
    // configuration
    // ------------------------------
    fsmConfigRegs #(.MemDepth(MemDepth)) cfgRegs0 (
        .Clock    (Clock),
        .rstN     (rstN),
        .CfgWrite (CfgWrite),
        .CfgSel   (CfgSel),
        .CfgData  (CfgData),
        .cfg      (cfg)
    );

    // ------------------------------
    // sequencer
    // ------------------------------
    sdramFsm #(.MemDepth(MemDepth)) fsm0 (
        .Clock         (Clock),
        .rstN          (rstN),
        .StartWr       (StartWr),
        .cfg           (cfg),
        .MemData       (memData),
        .WrRequest     (wrRequest),
        .wrReq         (wrReq),
        .RdRequest     (rdRequest),
        .rdReq         (rdReq),
        .ReadValid     (ReadValid),
        .ReadData      (ReadData),
        .ReadIndex     (ReadIndex),
        .Busy          (Busy),
        .Done          (Done),
        .MismatchCount (MismatchCount)
    );

    // memory model
    demoSdram #(.MemDepth(MemDepth)) mem0 (
        .Clock     (Clock),
        .WrRequest (wrRequest),
        .wrReq     (wrReq),
        .RdRequest (rdRequest),
        .rdReq     (rdReq),
        .MemData   (memData)
    );

endmodule

/* verif/sdramFsmTb.sv */
// testbench for the write-then-read sequencer top level
// runs with MemDepth 64 and drives inputs on the falling clock edge
// expected words come from the word rule and a model of the memory array
// the run ends at a cycle limit sized from the worst case of all tests

module sdramFsmTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MemDepth = 64;

    // budget per run is 2N+2 plus 20 with random runs taken at N = 100
    localparam int RunBudget = (2 * 16 + 22) + (2 * 30 + 22) + (2 * 70 + 22)
                             + (2 * 20 + 22) + (2 * 1 + 22) + 8 * (2 * 100 + 22);
    localparam int CycleLimit = RunBudget * 3 / 2;

    // abcdefg patterns for digits 0..F
    localparam logic [6:0] SegTable [16] = '{
        7'h7E, 7'h30, 7'h6D, 7'h79, 7'h33, 7'h5B, 7'h5F, 7'h70,
        7'h7F, 7'h7B, 7'h77, 7'h1F, 7'h4E, 7'h3D, 7'h4F, 7'h47
    };

    logic                    Clock;
    logic                    rstN;
    logic                    StartWr;
    logic                    CfgWrite;
    logic [1:0]              CfgSel;
    logic [7:0]              CfgData;
    logic                    ReadValid;
    sdramFsmPkg::sdramWord_u ReadData;
    logic [7:0]              ReadIndex;
    logic                    Busy;
    logic                    Done;
    logic [7:0]              MismatchCount;

    sdramFsmPkg::cfg_t shadowCfg;   // what the config block should hold
    sdramFsmPkg::cfg_t runCfg;      // copy the DUT took at start
    int                rdSeen;      // ReadValid pulses in this run
    bit                runActive;
    int                errors;
    int                passCount;
    int                failCount;
    int                cycleCount;
    int                seed;

    sdramFsmTop #(.MemDepth(MemDepth)) dut0 (
        .Clock         (Clock),
        .rstN          (rstN),
        .StartWr       (StartWr),
        .CfgWrite      (CfgWrite),
        .CfgSel        (CfgSel),
        .CfgData       (CfgData),
        .ReadValid     (ReadValid),
        .ReadData      (ReadData),
        .ReadIndex     (ReadIndex),
        .Busy          (Busy),
        .Done          (Done),
        .MismatchCount (MismatchCount)
    );

    always #20 Clock = ~Clock;   // 40 ns period

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic int effCount(sdramFsmPkg::cfg_t c);
        return (c.wordCount == 8'd0) ? 1 : int'(c.wordCount);
    endfunction

    function automatic int addrOf(sdramFsmPkg::cfg_t c, int idx, int depth);
        return (int'(c.baseAddr) + idx) % depth;
    endfunction

    // word i by the word rule
    function automatic sdramFsmPkg::sdramWord_u refWord(sdramFsmPkg::cfg_t c, int idx);
        sdramFsmPkg::sdramWord_u w;
        logic [3:0]              digit;
        digit      = 4'((int'(c.firstDigit) + idx) % 16);
        w.seg.tag  = 8'(idx % 256);
        w.seg.dp   = idx[0];   // odd index
        w.seg.segs = SegTable[digit];
        return w;
    endfunction

    // read i sees the last write that landed on its address
    function automatic sdramFsmPkg::sdramWord_u expectedRead(sdramFsmPkg::cfg_t c,
                                                              int idx, int depth);
        int j;
        j = idx;
        while (j + depth < effCount(c))
            j += depth;
        return refWord(c, j);
    endfunction

    // whole run through a model array with writes first then compares
    function automatic logic [7:0] modelMismatches(sdramFsmPkg::cfg_t c, int depth);
        sdramFsmPkg::sdramWord_u modelMem [MemDepth];
        int                      n;
        int                      cnt;
        n   = effCount(c);
        cnt = 0;
        for (int i = 0; i < n; i++)
            modelMem[addrOf(c, i, depth)] = refWord(c, i);
        for (int i = 0; i < n; i++)
            if (modelMem[addrOf(c, i, depth)] != refWord(c, i))
                cnt++;
        return (cnt > 255) ? 8'hFF : 8'(cnt);   // saturating
    endfunction

    function automatic sdramFsmPkg::cfg_t applyCfg(sdramFsmPkg::cfg_t c, logic [1:0] sel,
                                                   logic [7:0] data);
        sdramFsmPkg::cfg_t nc;
        nc = c;
        case (sel)
            2'd0: nc.baseAddr = sdramFsmPkg::ADDR_BITS'(int'(data) % MemDepth);
            2'd1: nc.wordCount = (data == 8'd0) ? 8'd1 : data;
            2'd2: nc.firstDigit = data[3:0];
            default: ;   // select 3 does nothing
        endcase
        return nc;
    endfunction

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic checkWord(input string name, input sdramFsmPkg::sdramWord_u got,
                             input sdramFsmPkg::sdramWord_u exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkCount(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // readback checker with the index counting the pulses
    always @(posedge Clock) begin
        if (rstN && ReadValid) begin
            if (!runActive) begin
                errors++;
                $display("ReadValid pulsed while no run was going at %0t", $time);
            end else begin
                checkWord("ReadData", ReadData, expectedRead(runCfg, rdSeen, MemDepth));
                checkCount("ReadIndex", ReadIndex, 8'(rdSeen));
                rdSeen++;
            end
        end
    end

    // watchdog
    always @(posedge Clock) begin
        cycleCount++;
        if (cycleCount >= CycleLimit) begin
            $display("run stopped after %0d cycles without finishing", cycleCount);
            $display("Testbench failed");
            $finish;
        end
    end

    // ------------------------------
    // stimulus helpers
    // ------------------------------
    task automatic driveCfg(input logic [1:0] sel, input logic [7:0] data);
        CfgWrite  = 1'b1;
        CfgSel    = sel;
        CfgData   = data;
        shadowCfg = applyCfg(shadowCfg, sel, data);
    endtask

    task automatic writeCfg(input logic [1:0] sel, input logic [7:0] data);
        @(negedge Clock);
        driveCfg(sel, data);
        @(negedge Clock);
        CfgWrite = 1'b0;
    endtask

    // one start pulse then wait for Done and check latency, pulses and count
    task automatic runCheck(input bit disturb);
        int         n;
        int         cyc;
        bit         doneSeen;
        bit         busyLost;
        logic [7:0] finalCount;
        n         = effCount(shadowCfg);
        runCfg    = shadowCfg;
        rdSeen    = 0;
        runActive = 1'b1;
        @(negedge Clock);
        StartWr = 1'b1;
        @(posedge Clock);   // t0
        cyc        = 0;
        doneSeen   = 1'b0;
        busyLost   = 1'b0;
        finalCount = 8'd0;
        while (!doneSeen && cyc < 2 * n + 12) begin
            @(negedge Clock);
            StartWr  = 1'b0;
            CfgWrite = 1'b0;
            if (disturb) begin
                case (cyc)
                    2, 7: StartWr = 1'b1;          // dropped while busy
                    3: driveCfg(2'd0, 8'd50);
                    4: driveCfg(2'd1, 8'd0);       // stored as 1
                    5: driveCfg(2'd2, 8'hAC);
                    default: ;
                endcase
                if (cyc == 2 * n + 1)
                    StartWr = 1'b1;                // lands in the Done cycle
            end
            @(posedge Clock);
            cyc++;
            if (Done) begin
                doneSeen   = 1'b1;
                finalCount = MismatchCount;
            end
            if (!Busy && !busyLost) begin
                busyLost = 1'b1;
                errors++;
                $display("Busy went low %0d cycles into a %0d-word run", cyc, n);
            end
        end
        @(negedge Clock);
        StartWr = 1'b0;
        if (!doneSeen) begin
            errors++;
            $display("Done never came for a %0d-word run", n);
        end else begin
            if (cyc != 2 * n + 2) begin
                errors++;
                $display("Done came %0d cycles after start, expected %0d", cyc, 2 * n + 2);
            end
            if (rdSeen != n) begin
                errors++;
                $display("Done came after %0d ReadValid pulses, expected %0d", rdSeen, n);
            end
            checkCount("MismatchCount", finalCount, modelMismatches(runCfg, MemDepth));
        end
        if (Busy) begin
            errors++;
            $display("Busy stayed high after Done");
        end
        runActive = 1'b0;
    endtask

    task automatic reportTest(input int num, input string name, input int errBefore);
        if (errors == errBefore) begin
            passCount++;
            $display("test %0d %s: ok", num, name);
        end else begin
            failCount++;
            $display("test %0d %s: FAILED with %0d errors", num, name, errors - errBefore);
        end
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        int         errBefore;
        logic [7:0] rBase;
        logic [7:0] rCount;
        logic [7:0] rDigit;
        Clock      = 1'b0;
        rstN       = 1'b0;
        StartWr    = 1'b0;
        CfgWrite   = 1'b0;
        CfgSel     = 2'd0;
        CfgData    = 8'd0;
        runActive  = 1'b0;
        rdSeen     = 0;
        errors     = 0;
        passCount  = 0;
        failCount  = 0;
        cycleCount = 0;
        seed       = 32'h9611e83f;
        shadowCfg.baseAddr   = '0;   // reset defaults
        shadowCfg.wordCount  = 8'd16;
        shadowCfg.firstDigit = 4'h0;
        runCfg = shadowCfg;
        repeat (5) @(negedge Clock);
        rstN = 1'b1;

        // 16 words from address 0 with reset defaults
        errBefore = errors;
        @(negedge Clock);
        if (ReadValid || Done || Busy) begin
            errors++;
            $display("outputs active after reset");
        end
        checkCount("MismatchCount", MismatchCount, 8'd0);
        runCheck(1'b0);
        reportTest(1, "reset defaults", errBefore);

        // wraps past address 63
        errBefore = errors;
        writeCfg(2'd0, 8'd40);
        writeCfg(2'd1, 8'd30);
        writeCfg(2'd2, 8'd9);
        runCheck(1'b0);
        reportTest(2, "configured run", errBefore);

        // 70 words over 64 entries overwrite the first six
        errBefore = errors;
        writeCfg(2'd0, 8'd5);
        writeCfg(2'd1, 8'd70);
        runCheck(1'b0);
        reportTest(3, "overlap detection", errBefore);

        // start and config writes mid-run then a one-word run
        errBefore = errors;
        writeCfg(2'd0, 8'd12);
        writeCfg(2'd1, 8'd20);
        writeCfg(2'd2, 8'd3);
        runCheck(1'b1);
        runCheck(1'b0);
        reportTest(4, "ignored inputs", errBefore);

        for (int t = 0; t < 8; t++) begin
            errBefore = errors;
            rBase  = 8'($random(seed));
            rCount = 8'(1 + ({$random(seed)} % 100));
            rDigit = 8'($random(seed));
            writeCfg(2'd0, rBase);
            writeCfg(2'd1, rCount);
            writeCfg(2'd2, rDigit);
            runCheck(1'b0);
            reportTest(5 + t, "random run", errBefore);
        end

        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* all.f */
src/sdramFsmPkg.sv
src/segmentEncoder.sv
src/fsmConfigRegs.sv
src/sdramFsm.sv
src/demoSdram.sv
src/sdramFsmTop.sv
verif/sdramFsmTb.sv

/* Makefile */
# Verilator build and run of the sequencer testbench

SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = sdramFsmTb
FILELIST = all.f
OBJDIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(OBJDIR)
